// File: Makefile
# Verilator simulation of the two-pass histogram peak locator

VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/sifhBusPkg.sv
package sifhBusPkg;

    typedef logic [31:0] axiDataT;
    typedef logic [4:0] axiAddrT; // covers offsets up to 0x1f

    typedef enum logic [1:0] {
        RESP_OKAY = 2'd0,
        RESP_SLVERR = 2'd2
    } axiRespT;

    // write side walks all four, read side only idle and resp
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_GOT_ADDR,
        RS_GOT_DATA,
        RS_RESP
    } regStateT;

endpackage

// File: common/sifhHistPkg.sv
`include "sifh_macros.svh"

package sifhHistPkg;

    typedef logic [`Np-1:0] timestampT; // raw tdc word
    typedef logic [`RAM_ADDR-1:0] binIdxT; // bin index, same as sram address
    typedef logic [`peakMax-1:0] binCntT; // saturating count
    typedef logic [23:0] eventCntT; // events per pass

    // two passes, each cleared, built and scanned
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_CLEAR1,
        PH_BUILD1,
        PH_SCAN1,
        PH_FILTER,
        PH_CLEAR2,
        PH_BUILD2,
        PH_SCAN2
    } phaseT;

endpackage

// File: common/sifh_macros.svh
`ifndef SIFH_MACROS_SVH
`define SIFH_MACROS_SVH

`define Np 12 // tdc timestamp width
`define Nb 6 // coarse and fine field width
`define peakMax 16 // bin count width
`define RAM_ADDR 6
`define BIN_NUM 64

// byte offsets on the host bus
`define REG_CTRL 5'h00
`define REG_STATUS 5'h04
`define REG_EVENTS 5'h08
`define REG_RESULT 5'h0C
`define REG_PEAKCNT 5'h10

`endif

// File: files.f
+incdir+common
common/sifhBusPkg.sv
common/sifhHistPkg.sv
histogram/histSram.sv
histogram/histBuilder.sv
hw/peakFinder.sv
hw/sifhRegs.sv
hw/sifhCtrl.sv
hw/sifhTop.sv
testbench/sifhTb.sv

// File: histogram/histBuilder.sv
`timescale 1ns/1ps

module histBuilder import sifhHistPkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   binValid,
    input  binIdxT binIdx,
    output logic   ramRe,
    output binIdxT ramRaddr,
    input  binCntT ramRdata,
    output logic   ramWe,
    output binIdxT ramWaddr,
    output binCntT ramWdata,
    output logic   buildIdle
);
    logic   s1Valid, s2Valid, s3Valid;
    binIdxT s1Idx, s2Idx, s3Idx;
    binCntT s2Cnt, s3Cnt;
    binCntT curCnt;

    assign ramRe     = binValid; // read issued with the strobe
    assign ramRaddr  = binIdx;
    assign ramWe     = s2Valid; // stage 2 owns the write port
    assign ramWaddr  = s2Idx;
    assign ramWdata  = s2Cnt;
    assign buildIdle = !(s1Valid || s2Valid);

    // sram data in stage 1 misses the pending write in stage 2
    // and the one retired at the last edge, now held in stage 3
    always_comb begin
        curCnt = ramRdata;
        if (s3Valid && s3Idx == s1Idx) curCnt = s3Cnt;
        if (s2Valid && s2Idx == s1Idx) curCnt = s2Cnt; // newest wins
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= binValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Idx <= binIdx;
        s2Idx <= s1Idx;
        s3Idx <= s2Idx;
        s2Cnt <= (curCnt == '1) ? curCnt : curCnt + 1'b1; // saturate at 0xffff
        s3Cnt <= s2Cnt;
    end

endmodule

// File: histogram/histSram.sv
`timescale 1ns/1ps
`include "sifh_macros.svh"

module histSram import sifhHistPkg::*; (
    input  logic   clk,
    input  logic   we,
    input  binIdxT waddr,
    input  binCntT wdata,
    input  logic   re,
    input  binIdxT raddr,
    output binCntT rdata
);
    binCntT mem [`BIN_NUM];

    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
        if (re) rdata <= mem[raddr]; // old data on a same-address write
    end

endmodule

// File: hw/peakFinder.sv
`timescale 1ns/1ps
`include "sifh_macros.svh"

module peakFinder import sifhHistPkg::*; (
    input  logic   clk,
    input  logic   res,
    input  logic   scanStart,
    output logic   ramRe,
    output binIdxT ramRaddr,
    input  binCntT ramRdata,
    output logic   scanDone,
    output binIdxT peakBin,
    output binCntT peakCnt
);
    logic   scanning;
    logic   rdValid;
    logic   rdLast;
    binIdxT rdAddr;
    binIdxT rdIdx;

    assign ramRe    = scanning;
    assign ramRaddr = rdAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            rdValid  <= 1'b0;
            rdLast   <= 1'b0;
            scanDone <= 1'b0;
            rdAddr   <= '0;
            rdIdx    <= '0;
            peakBin  <= '0;
            peakCnt  <= '0;
        end else begin
            rdValid  <= scanning; // data back one cycle after the read
            rdIdx    <= rdAddr;
            rdLast   <= scanning && rdAddr == binIdxT'(`BIN_NUM - 1);
            scanDone <= rdLast;
            // strictly greater keeps the lowest bin on a tie
            if (rdValid && ramRdata > peakCnt) begin
                peakBin <= rdIdx;
                peakCnt <= ramRdata;
            end
            if (scanStart) begin
                scanning <= 1'b1;
                rdAddr   <= '0;
                peakBin  <= '0;
                peakCnt  <= '0;
            end else if (scanning) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == binIdxT'(`BIN_NUM - 1)) scanning <= 1'b0;
            end
        end
    end

endmodule

// File: hw/sifhCtrl.sv
`timescale 1ns/1ps
`include "sifh_macros.svh"

module sifhCtrl import sifhHistPkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      start,
    input  eventCntT  eventCount,
    input  timestampT tdcData,
    input  logic      tdcValid,
    output logic      tdcReady,
    output logic      binValid,
    output binIdxT    binIdx,
    input  logic      buildIdle,
    input  logic      bldWe,
    input  binIdxT    bldWaddr,
    input  binCntT    bldWdata,
    input  logic      bldRe,
    input  binIdxT    bldRaddr,
    output binCntT    bldRdata,
    output logic      scanStart,
    input  logic      scanDone,
    input  binIdxT    peakBin,
    input  binCntT    peakCnt,
    input  logic      fndRe,
    input  binIdxT    fndRaddr,
    output binCntT    fndRdata,
    output logic      we,
    output binIdxT    waddr,
    output binCntT    wdata,
    output logic      re,
    output binIdxT    raddr,
    input  binCntT    rdata,
    output logic      busy,
    output logic      done,
    output timestampT result,
    output binCntT    peakCount
);
    phaseT    phase;
    binIdxT   clrCnt;
    eventCntT evCnt;
    binIdxT   windowBin;
    binIdxT   coarseIdx;
    logic     building, clearing, targetHit, tdcFire;

    assign coarseIdx = tdcData[`Np-1 -: `Nb];
    assign building  = phase == PH_BUILD1 || phase == PH_BUILD2;
    assign clearing  = phase == PH_CLEAR1 || phase == PH_CLEAR2;
    assign targetHit = evCnt >= eventCount;
    assign tdcReady  = building && !targetHit;
    assign tdcFire   = tdcValid && tdcReady;
    // fine pass still counts dropped events toward the target
    assign binValid  = tdcFire && (phase == PH_BUILD1 || coarseIdx == windowBin);
    assign binIdx    = (phase == PH_BUILD1) ? coarseIdx : tdcData[`Nb-1:0];
    assign busy      = phase != PH_IDLE;
    assign bldRdata  = rdata;
    assign fndRdata  = rdata;

    // sram port owner follows the phase
    always_comb begin
        we    = 1'b0;
        waddr = clrCnt;
        wdata = '0;
        re    = 1'b0;
        raddr = fndRaddr;
        if (clearing) begin
            we = 1'b1; // zero fill
        end else if (building) begin
            we    = bldWe;
            waddr = bldWaddr;
            wdata = bldWdata;
            re    = bldRe;
            raddr = bldRaddr;
        end else if (phase == PH_SCAN1 || phase == PH_SCAN2) begin
            re = fndRe;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase     <= PH_IDLE;
            clrCnt    <= '0;
            evCnt     <= '0;
            windowBin <= '0;
            scanStart <= 1'b0;
            done      <= 1'b0;
            result    <= '0;
            peakCount <= '0;
        end else begin
            scanStart <= 1'b0;
            if (clearing) clrCnt <= clrCnt + 1'b1; // wraps back to 0 after the last bin
            if (tdcFire) evCnt <= evCnt + 1'b1;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        done  <= 1'b0;
                        phase <= PH_CLEAR1;
                    end
                end
                PH_CLEAR1, PH_CLEAR2: begin
                    if (clrCnt == binIdxT'(`BIN_NUM - 1)) begin
                        evCnt <= '0;
                        phase <= (phase == PH_CLEAR1) ? PH_BUILD1 : PH_BUILD2;
                    end
                end
                PH_BUILD1, PH_BUILD2: begin
                    if (targetHit && buildIdle) begin // last write has landed
                        scanStart <= 1'b1;
                        phase     <= (phase == PH_BUILD1) ? PH_SCAN1 : PH_SCAN2;
                    end
                end
                PH_SCAN1: if (scanDone) phase <= PH_FILTER;
                PH_FILTER: begin
                    windowBin <= peakBin; // coarse peak picks the window
                    phase     <= PH_CLEAR2;
                end
                PH_SCAN2: begin
                    if (scanDone) begin
                        result    <= {windowBin, peakBin};
                        peakCount <= peakCnt;
                        done      <= 1'b1;
                        phase     <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

// File: hw/sifhRegs.sv
`timescale 1ns/1ps
`include "sifh_macros.svh"

module sifhRegs import sifhBusPkg::*, sifhHistPkg::*; (
    input  logic       clk,
    input  logic       res,
    input  axiAddrT    awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axiDataT    wdata,
    input  logic [3:0] wstrb,
    input  logic       wvalid,
    output logic       wready,
    output axiRespT    bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axiAddrT    araddr,
    input  logic       arvalid,
    output logic       arready,
    output axiDataT    rdata,
    output axiRespT    rresp,
    output logic       rvalid,
    input  logic       rready,
    input  logic       busy,
    input  logic       done,
    input  timestampT  result,
    input  binCntT     peakCount,
    output logic       start,
    output eventCntT   eventCount
);
    regStateT   wState, rState;
    axiAddrT    awAddrQ, wrAddr;
    axiDataT    wDataQ, wrData, rdMux;
    logic [3:0] wStrbQ, wrStrb;
    logic       awFire, wFire, arFire, doWrite;

    function automatic logic isMapped(axiAddrT a);
        return a == `REG_CTRL || a == `REG_STATUS || a == `REG_EVENTS ||
               a == `REG_RESULT || a == `REG_PEAKCNT;
    endfunction

    assign awFire = awvalid && awready;
    assign wFire  = wvalid && wready;
    assign arFire = arvalid && arready;
    // take whichever half arrives this cycle, the other from its holding register
    assign wrAddr = awFire ? awaddr : awAddrQ;
    assign wrData = wFire ? wdata : wDataQ;
    assign wrStrb = wFire ? wstrb : wStrbQ;
    assign doWrite = (wState == RS_IDLE && awFire && wFire) ||
                     (wState == RS_GOT_ADDR && wFire) ||
                     (wState == RS_GOT_DATA && awFire);

    always_comb begin
        case (araddr)
            `REG_STATUS:  rdMux = {30'd0, done, busy};
            `REG_EVENTS:  rdMux = axiDataT'(eventCount);
            `REG_RESULT:  rdMux = axiDataT'(result);
            `REG_PEAKCNT: rdMux = axiDataT'(peakCount);
            default:      rdMux = '0; // ctrl and unmapped read as zero
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wState     <= RS_IDLE;
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            start      <= 1'b0;
            eventCount <= '0;
        end else begin
            start <= doWrite && wrAddr == `REG_CTRL && wrStrb[0] && wrData[0]; // one cycle pulse
            if (doWrite && wrAddr == `REG_EVENTS) begin
                for (int i = 0; i < 3; i++) begin
                    if (wrStrb[i]) eventCount[8*i +: 8] <= wrData[8*i +: 8];
                end
            end
            case (wState)
                RS_IDLE: begin
                    awready <= 1'b1;
                    wready  <= 1'b1;
                    if (doWrite) begin
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        bvalid  <= 1'b1;
                        wState  <= RS_RESP;
                    end else if (awFire) begin
                        awready <= 1'b0;
                        wState  <= RS_GOT_ADDR;
                    end else if (wFire) begin
                        wready <= 1'b0;
                        wState <= RS_GOT_DATA;
                    end
                end
                RS_GOT_ADDR, RS_GOT_DATA: begin
                    if (doWrite) begin
                        awready <= 1'b0;
                        wready  <= 1'b0;
                        bvalid  <= 1'b1;
                        wState  <= RS_RESP;
                    end
                end
                RS_RESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        wState <= RS_IDLE;
                    end
                end
                default: wState <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rState  <= RS_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rState == RS_IDLE) begin
            arready <= !arFire;
            if (arFire) begin
                rvalid <= 1'b1;
                rState <= RS_RESP;
            end
        end else if (rready) begin
            rvalid <= 1'b0;
            rState <= RS_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (awFire) awAddrQ <= awaddr;
        if (wFire) begin
            wDataQ <= wdata;
            wStrbQ <= wstrb;
        end
        if (doWrite) bresp <= isMapped(wrAddr) ? RESP_OKAY : RESP_SLVERR;
        if (arFire) begin
            rdata <= rdMux;
            rresp <= isMapped(araddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// File: hw/sifhTop.sv
`timescale 1ns/1ps

module sifhTop import sifhBusPkg::*, sifhHistPkg::*; (
    input  logic      clk,
    input  logic      res,
    input  axiAddrT   awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axiDataT   wdata,
    input  logic [3:0] wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axiRespT   bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axiAddrT   araddr,
    input  logic      arvalid,
    output logic      arready,
    output axiDataT   rdata,
    output axiRespT   rresp,
    output logic      rvalid,
    input  logic      rready,
    input  timestampT tdcData,
    input  logic      tdcValid,
    output logic      tdcReady
);
    logic      start, busy, done;
    eventCntT  eventCount;
    timestampT result;
    binCntT    peakCount;
    logic      binValid, buildIdle;
    binIdxT    binIdx;
    logic      bldRe, bldWe, fndRe, memRe, memWe;
    binIdxT    bldRaddr, bldWaddr, fndRaddr, memRaddr, memWaddr;
    binCntT    bldRdata, bldWdata, fndRdata, memRdata, memWdata;
    logic      scanStart, scanDone;
    binIdxT    peakBin;
    binCntT    peakCnt;

    sifhRegs regsInst (.*);

    sifhCtrl ctrlInst (
        .*,
        .we(memWe), .waddr(memWaddr), .wdata(memWdata),
        .re(memRe), .raddr(memRaddr), .rdata(memRdata)
    );

    histBuilder builderInst (
        .*,
        .ramRe(bldRe), .ramRaddr(bldRaddr), .ramRdata(bldRdata),
        .ramWe(bldWe), .ramWaddr(bldWaddr), .ramWdata(bldWdata)
    );

    histSram sramInst (
        .clk(clk),
        .we(memWe), .waddr(memWaddr), .wdata(memWdata),
        .re(memRe), .raddr(memRaddr), .rdata(memRdata)
    );

    peakFinder finderInst (
        .*,
        .ramRe(fndRe), .ramRaddr(fndRaddr), .ramRdata(fndRdata)
    );

endmodule

// File: testbench/sifhTb.sv
`timescale 1ns/1ps
`include "sifh_macros.svh"

module sifhTb import sifhBusPkg::*, sifhHistPkg::*;;
    localparam int WAIT_LIMIT = 2000; // cycles per handshake
    localparam int POLL_LIMIT = 400; // status reads while waiting for done

    logic       clk;
    logic       res;
    axiAddrT    awaddr;
    logic       awvalid;
    logic       awready;
    axiDataT    wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       wready;
    axiRespT    bresp;
    logic       bvalid;
    logic       bready;
    axiAddrT    araddr;
    logic       arvalid;
    logic       arready;
    axiDataT    rdata;
    axiRespT    rresp;
    logic       rvalid;
    logic       rready;
    timestampT  tdcData;
    logic       tdcValid;
    logic       tdcReady;

    int          checkCnt;
    int          errorCnt;
    int          timeoutCnt;
    logic [31:0] rngState;
    timestampT   evList[$]; // stream sent in both passes
    binCntT      coarseHist [`BIN_NUM];
    binCntT      fineHist [`BIN_NUM];

    sifhTop DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic timestampT randomStamp();
        rngState = xorshift32(rngState);
        return rngState[`Np-1:0];
    endfunction

    task automatic checkTimestamp(string name, timestampT exp, timestampT act);
        checkCnt++;
        if (act !== exp) begin
            errorCnt++;
            $display("Fail %s: expected 0x%03h, actual 0x%03h", name, exp, act);
        end
    endtask

    task automatic checkCount(string name, binCntT exp, binCntT act);
        checkCnt++;
        if (act !== exp) begin
            errorCnt++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkResp(string name, axiRespT exp, axiRespT act);
        checkCnt++;
        if (act !== exp) begin
            errorCnt++;
            $display("Fail %s: expected resp %0d, actual resp %0d", name, exp, act);
        end
    endtask

    task automatic checkWord(string name, axiDataT exp, axiDataT act);
        checkCnt++;
        if (act !== exp) begin
            errorCnt++;
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic noteTimeout(string what);
        timeoutCnt++;
        $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic axiWrite(axiAddrT addr, axiDataT data, output axiRespT resp);
        int   waitCnt;
        logic awPend;
        logic wPend;
        resp = RESP_SLVERR;
        waitCnt = 0;
        @(negedge clk);
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = 4'hF;
        wvalid = 1'b1;
        while ((awvalid || wvalid) && waitCnt < WAIT_LIMIT) begin
            awPend = awvalid && !awready; // ready now means taken at the next edge
            wPend = wvalid && !wready;
            @(negedge clk);
            if (!awPend) awvalid = 1'b0;
            if (!wPend) wvalid = 1'b0;
            waitCnt++;
        end
        if (awvalid || wvalid) begin
            noteTimeout("write address or data handshake");
            awvalid = 1'b0;
            wvalid = 1'b0;
        end else begin
            bready = 1'b1;
            waitCnt = 0;
            while (!bvalid && waitCnt < WAIT_LIMIT) begin
                @(negedge clk);
                waitCnt++;
            end
            if (!bvalid) begin
                noteTimeout("write response");
            end else begin
                resp = bresp;
            end
            @(negedge clk);
            bready = 1'b0;
        end
    endtask

    task automatic axiRead(axiAddrT addr, output axiDataT data, output axiRespT resp);
        int waitCnt;
        data = '0;
        resp = RESP_SLVERR;
        waitCnt = 0;
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        while (!arready && waitCnt < WAIT_LIMIT) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!arready) begin
            noteTimeout("read address handshake");
            arvalid = 1'b0;
        end else begin
            @(negedge clk); // address taken at the edge just passed
            arvalid = 1'b0;
            rready = 1'b1;
            waitCnt = 0;
            while (!rvalid && waitCnt < WAIT_LIMIT) begin
                @(negedge clk);
                waitCnt++;
            end
            if (!rvalid) begin
                noteTimeout("read data");
            end else begin
                data = rdata;
                resp = rresp;
            end
            @(negedge clk);
            rready = 1'b0;
        end
    endtask

    // one pass worth of events, back to back while tdcReady holds
    task automatic sendEvents();
        int waitCnt;
        @(negedge clk);
        for (int i = 0; i < evList.size(); i++) begin
            tdcData = evList[i];
            tdcValid = 1'b1;
            waitCnt = 0;
            while (!tdcReady && waitCnt < WAIT_LIMIT) begin
                @(negedge clk);
                waitCnt++;
            end
            if (!tdcReady) begin
                noteTimeout("tdcReady for the next event");
                break;
            end
            @(negedge clk); // accepted at the edge just passed
        end
        tdcValid = 1'b0;
    endtask

    function automatic binIdxT findPeak(binCntT hist [`BIN_NUM]);
        binIdxT best;
        best = '0;
        for (int b = 1; b < `BIN_NUM; b++) begin
            if (hist[b] > hist[best]) best = binIdxT'(b); // a tie keeps the lower bin
        end
        return best;
    endfunction

    // coarse histogram first, then the fine one inside the window on its peak
    task automatic modelRun(output timestampT expTs, output binCntT expCnt);
        timestampT ts;
        binIdxT    hi;
        binIdxT    lo;
        binIdxT    coarsePeak;
        binIdxT    finePeak;
        for (int b = 0; b < `BIN_NUM; b++) begin
            coarseHist[b] = '0;
            fineHist[b] = '0;
        end
        foreach (evList[i]) begin
            ts = evList[i];
            hi = ts[`Np-1 -: `Nb];
            if (coarseHist[hi] != '1) coarseHist[hi]++;
        end
        coarsePeak = findPeak(coarseHist);
        foreach (evList[i]) begin
            ts = evList[i];
            hi = ts[`Np-1 -: `Nb];
            lo = ts[`Nb-1:0];
            if (hi == coarsePeak && fineHist[lo] != '1) fineHist[lo]++;
        end
        finePeak = findPeak(fineHist);
        expTs = {coarsePeak, finePeak};
        expCnt = fineHist[finePeak];
    endtask

    task automatic runHistogram(string name, logic pokeStart,
                                output timestampT gotTs, output binCntT gotCnt);
        axiRespT   resp;
        axiDataT   word;
        timestampT expTs;
        binCntT    expCnt;
        int        polls;
        axiWrite(`REG_EVENTS, axiDataT'(evList.size()), resp);
        checkResp({name, " events write"}, RESP_OKAY, resp);
        axiWrite(`REG_CTRL, 32'h1, resp);
        axiRead(`REG_STATUS, word, resp);
        checkWord({name, " status while busy"}, 32'h1, word); // done cleared by start
        sendEvents(); // coarse pass
        if (pokeStart) begin
            axiWrite(`REG_CTRL, 32'h1, resp); // a restart here would starve the fine pass
            checkResp({name, " start while busy"}, RESP_OKAY, resp);
        end
        sendEvents(); // fine pass, same stream
        polls = 0;
        word = '0;
        while (!word[1] && polls < POLL_LIMIT) begin
            axiRead(`REG_STATUS, word, resp);
            polls++;
        end
        if (!word[1]) begin
            timeoutCnt++;
            $display("Timeout: %s never set done in STATUS", name);
        end else begin
            checkWord({name, " status when done"}, 32'h2, word);
        end
        modelRun(expTs, expCnt);
        axiRead(`REG_RESULT, word, resp);
        gotTs = timestampT'(word);
        checkWord({name, " result word"}, axiDataT'(expTs), word);
        axiRead(`REG_PEAKCNT, word, resp);
        gotCnt = binCntT'(word);
        checkCount({name, " peak count"}, expCnt, gotCnt);
    endtask

    task automatic testRegisterAccess();
        axiRespT resp;
        axiDataT word;
        axiRead(`REG_STATUS, word, resp);
        checkWord("status after reset", 32'h0, word);
        checkResp("status read", RESP_OKAY, resp);
        axiWrite(`REG_EVENTS, 32'h12AB_CDEF, resp);
        checkResp("events write", RESP_OKAY, resp);
        axiRead(`REG_EVENTS, word, resp);
        checkWord("events readback", 32'h00AB_CDEF, word); // 24 bits kept
        axiWrite(`REG_RESULT, 32'hFFFF_FFFF, resp);
        checkResp("result write", RESP_OKAY, resp);
        axiRead(`REG_RESULT, word, resp);
        checkWord("result after write", 32'h0, word);
        axiWrite(5'h14, 32'h1, resp);
        checkResp("unmapped write", RESP_SLVERR, resp);
        axiRead(5'h14, word, resp);
        checkResp("unmapped read", RESP_SLVERR, resp);
        checkWord("unmapped read data", 32'h0, word);
    endtask

    task automatic testSinglePeak();
        timestampT gotTs;
        binCntT    gotCnt;
        evList.delete();
        for (int i = 0; i < 200; i++) begin
            if (i % 5 < 3) begin
                evList.push_back(12'hA37);
            end else begin
                evList.push_back(randomStamp()); // background
            end
        end
        runHistogram("single peak", 1'b0, gotTs, gotCnt);
        checkTimestamp("single peak stamp", 12'hA37, gotTs);
    endtask

    task automatic testSameBinBurst();
        timestampT gotTs;
        binCntT    gotCnt;
        evList.delete();
        evList.push_back(12'h7C0);
        evList.push_back(12'h3C9);
        evList.push_back(12'h001);
        evList.push_back(12'hFFF);
        for (int i = 0; i < 40; i++) evList.push_back(12'h3C4);
        runHistogram("same-bin burst", 1'b0, gotTs, gotCnt);
        checkTimestamp("burst stamp", 12'h3C4, gotTs);
        checkCount("burst count", 16'd40, gotCnt);
    endtask

    // coarse 20 and 10 tie at ten events, fine 9 and 5 tie at four
    task automatic testWindowAndTies();
        timestampT gotTs;
        binCntT    gotCnt;
        evList.delete();
        for (int i = 0; i < 6; i++) evList.push_back(12'h503);
        for (int i = 0; i < 4; i++) evList.push_back(timestampT'(12'h510 + i));
        for (int i = 0; i < 4; i++) begin
            evList.push_back(12'h289);
            evList.push_back(12'h285);
        end
        evList.push_back(12'h29E);
        evList.push_back(12'h29E);
        for (int i = 0; i < 3; i++) evList.push_back(12'hA07);
        runHistogram("window and ties", 1'b0, gotTs, gotCnt);
        checkTimestamp("tie stamp", 12'h285, gotTs);
        checkCount("tie count", 16'd4, gotCnt);
    endtask

    task automatic testRestart();
        timestampT gotTs;
        binCntT    gotCnt;
        evList.delete();
        for (int i = 0; i < 60; i++) begin
            evList.push_back((i % 3 == 0) ? randomStamp() : 12'h155);
        end
        runHistogram("restart first run", 1'b1, gotTs, gotCnt);
        checkTimestamp("restart first stamp", 12'h155, gotTs);
        // same peak bin again, so stale bins would inflate the count
        evList.delete();
        for (int i = 0; i < 30; i++) begin
            evList.push_back((i % 3 == 0) ? randomStamp() : 12'h155);
        end
        runHistogram("restart second run", 1'b0, gotTs, gotCnt);
        checkTimestamp("restart second stamp", 12'h155, gotTs);
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        tdcData = '0;
        tdcValid = 1'b0;
        checkCnt = 0;
        errorCnt = 0;
        timeoutCnt = 0;
        rngState = 32'd85;
        repeat (16) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        testRegisterAccess();
        testSinglePeak();
        testSameBinBurst();
        testWindowAndTies();
        testRestart();
        $display("checks %0d, errors %0d, timeouts %0d", checkCnt, errorCnt, timeoutCnt);
        if (errorCnt == 0 && timeoutCnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
